// ==== verilog/basic_computer_pkg.sv ====
`default_nettype none

package basic_computer_pkg;

    ////////////////////////////////////////
    // Widths and instruction fields
    ////////////////////////////////////////

    localparam int word_width = 16;
    localparam int addr_width = 12;

    typedef logic [word_width-1:0] word_t;
    typedef logic [addr_width-1:0] addr_t;
    typedef logic [2:0] opcode_t;

    localparam opcode_t op_and      = 3'd0;
    localparam opcode_t op_add      = 3'd1;
    localparam opcode_t op_lda      = 3'd2;
    localparam opcode_t op_sta      = 3'd3;
    localparam opcode_t op_bun      = 3'd4;
    localparam opcode_t op_bsa      = 3'd5;
    localparam opcode_t op_isz      = 3'd6;
    localparam opcode_t op_register = 3'd7;

    // Register-reference bit positions in IR
    localparam int rr_cla = 11;
    localparam int rr_cle = 10;
    localparam int rr_cma = 9;
    localparam int rr_cme = 8;
    localparam int rr_cir = 7;
    localparam int rr_cil = 6;
    localparam int rr_inc = 5;
    localparam int rr_spa = 4;
    localparam int rr_sna = 3;
    localparam int rr_sza = 2;
    localparam int rr_sze = 1;
    localparam int rr_hlt = 0;

    localparam logic [2:0] seq_last = 3'd6;  // T6

    ////////////////////////////////////////
    // Bus sources and ALU operations
    ////////////////////////////////////////

    typedef logic [2:0] bus_source_t;

    localparam bus_source_t bus_none   = 3'd0;
    localparam bus_source_t bus_ar     = 3'd1;
    localparam bus_source_t bus_pc     = 3'd2;
    localparam bus_source_t bus_dr     = 3'd3;
    localparam bus_source_t bus_ac     = 3'd4;
    localparam bus_source_t bus_ir     = 3'd5;
    localparam bus_source_t bus_memory = 3'd7;

    typedef logic [3:0] alu_op_t;

    localparam alu_op_t alu_hold          = 4'd0;
    localparam alu_op_t alu_and           = 4'd1;
    localparam alu_op_t alu_add           = 4'd2;
    localparam alu_op_t alu_load          = 4'd3;
    localparam alu_op_t alu_complement_ac = 4'd4;
    localparam alu_op_t alu_complement_e  = 4'd5;
    localparam alu_op_t alu_rotate_right  = 4'd6;
    localparam alu_op_t alu_rotate_left   = 4'd7;
    localparam alu_op_t alu_increment     = 4'd8;
    localparam alu_op_t alu_clear_ac      = 4'd9;
    localparam alu_op_t alu_clear_e       = 4'd10;

    ////////////////////////////////////////
    // Shared structs
    ////////////////////////////////////////

    typedef struct packed {
        logic [7:0]  opcode;          // One-hot opcode
        logic        indirect;
        logic [11:0] register_op;     // Register-reference selection
        logic        register_valid;  // Exactly one selection bit set
    } decoded_instr_t;

    typedef struct packed {
        bus_source_t bus_source;
        alu_op_t     alu_op;
        logic        ar_load;
        logic        ar_increment;
        logic        pc_load;
        logic        pc_increment;
        logic        dr_load;
        logic        dr_increment;
        logic        ac_write;        // Writes AC and E from the ALU
        logic        ir_load;
        logic        memory_write;
    } control_word_t;

    typedef struct packed {
        addr_t pc;
        word_t ac;
        logic  e;
        logic  ac_zero;
        logic  ac_sign;
        logic  dr_zero;
    } machine_state_t;

    typedef struct packed {
        logic  valid;
        addr_t address;
        word_t data;
    } program_load_t;

    typedef struct packed {
        logic  valid;
        addr_t address;
        word_t data;
    } store_event_t;

endpackage

`default_nettype wire

// ==== verilog/instruction_decoder.sv ====
`default_nettype none

module instruction_decoder
    import basic_computer_pkg::*;
(
    input  word_t          ir,
    output decoded_instr_t decoded
);

    opcode_t opcode;

    assign opcode = ir[14:12];

    always_comb
    begin
        decoded = '0;
        decoded.opcode = 8'b1 << opcode;
        decoded.indirect = ir[15];
        if (opcode == op_register)
        begin
            decoded.register_op = ir[11:0];
            // I set means an I/O word, which this machine ignores
            decoded.register_valid = !ir[15] && $onehot(ir[11:0]);
        end
    end

    always_comb
    begin
        assert ($onehot(decoded.opcode))
            else $error("Opcode decode is not one-hot: %h", decoded.opcode);
    end

endmodule

`default_nettype wire

// ==== verilog/control_unit.sv ====
`default_nettype none

module control_unit
    import basic_computer_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  logic           start,
    input  decoded_instr_t decoded,
    input  machine_state_t status,
    output control_word_t  control,
    output logic           running
);

    logic [2:0] seq_count;
    logic       last;       // Instruction ends in this state
    logic       halt;
    logic       memory_reference;

    assign memory_reference = !decoded.opcode[op_register];

    ////////////////////////////////////////
    // Run flag and sequence counter
    ////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            running <= 1'b0;
            seq_count <= '0;
        end
        else
        begin
            if (!running)
                running <= start;
            else if (halt)
                running <= 1'b0;

            if (!running || last)
                seq_count <= '0;
            else
                seq_count <= seq_count + 3'd1;
        end
    end

    ////////////////////////////////////////
    // Control word per timing state
    ////////////////////////////////////////

    always_comb
    begin
        control = '0;
        control.bus_source = bus_none;
        control.alu_op = alu_hold;
        last = 1'b0;
        halt = 1'b0;
        if (running)
        begin
            case (seq_count)
                3'd0:
                begin
                    control.bus_source = bus_pc;  // AR <- PC
                    control.ar_load = 1'b1;
                end
                3'd1:
                begin
                    control.bus_source = bus_memory;  // IR <- M[AR], PC <- PC + 1
                    control.ir_load = 1'b1;
                    control.pc_increment = 1'b1;
                end
                3'd2:
                begin
                    control.bus_source = bus_ir;  // AR <- address field
                    control.ar_load = 1'b1;
                end
                3'd3:
                begin
                    if (memory_reference)
                    begin
                        if (decoded.indirect)
                        begin
                            control.bus_source = bus_memory;  // AR <- M[AR]
                            control.ar_load = 1'b1;
                        end
                    end
                    else
                    begin
                        last = 1'b1;
                        if (decoded.register_valid)
                        begin
                            if (decoded.register_op[rr_cla]) control.alu_op = alu_clear_ac;
                            if (decoded.register_op[rr_cle]) control.alu_op = alu_clear_e;
                            if (decoded.register_op[rr_cma]) control.alu_op = alu_complement_ac;
                            if (decoded.register_op[rr_cme]) control.alu_op = alu_complement_e;
                            if (decoded.register_op[rr_cir]) control.alu_op = alu_rotate_right;
                            if (decoded.register_op[rr_cil]) control.alu_op = alu_rotate_left;
                            if (decoded.register_op[rr_inc]) control.alu_op = alu_increment;
                            control.ac_write = (control.alu_op != alu_hold);
                            // Skips
                            control.pc_increment =
                                (decoded.register_op[rr_spa] && !status.ac_sign) ||
                                (decoded.register_op[rr_sna] && status.ac_sign) ||
                                (decoded.register_op[rr_sza] && status.ac_zero) ||
                                (decoded.register_op[rr_sze] && !status.e);
                            halt = decoded.register_op[rr_hlt];
                        end
                    end
                end
                3'd4:
                begin
                    if (decoded.opcode[op_sta])
                    begin
                        control.bus_source = bus_ac;  // M[AR] <- AC
                        control.memory_write = 1'b1;
                        last = 1'b1;
                    end
                    else if (decoded.opcode[op_bun])
                    begin
                        control.bus_source = bus_ar;  // PC <- AR
                        control.pc_load = 1'b1;
                        last = 1'b1;
                    end
                    else if (decoded.opcode[op_bsa])
                    begin
                        control.bus_source = bus_pc;  // M[AR] <- PC, AR <- AR + 1
                        control.memory_write = 1'b1;
                        control.ar_increment = 1'b1;
                    end
                    else
                    begin
                        control.bus_source = bus_memory;  // DR <- M[AR]
                        control.dr_load = 1'b1;
                    end
                end
                3'd5:
                begin
                    if (decoded.opcode[op_isz])
                        control.dr_increment = 1'b1;
                    else
                    begin
                        last = 1'b1;
                        if (decoded.opcode[op_bsa])
                        begin
                            control.bus_source = bus_ar;  // Jump past the return word
                            control.pc_load = 1'b1;
                        end
                        else
                        begin
                            if (decoded.opcode[op_and])
                                control.alu_op = alu_and;
                            else if (decoded.opcode[op_add])
                                control.alu_op = alu_add;
                            else
                                control.alu_op = alu_load;
                            control.ac_write = 1'b1;
                        end
                    end
                end
                3'd6:
                begin
                    control.bus_source = bus_dr;  // ISZ write back
                    control.memory_write = 1'b1;
                    control.pc_increment = status.dr_zero;
                    last = 1'b1;
                end
                default: last = 1'b1;
            endcase
        end
    end

    assert property (@(posedge clock) disable iff (reset) seq_count <= seq_last)
        else $error("Sequence counter past T6: %h", seq_count);

    assert property (@(posedge clock) disable iff (reset)
        !(control.memory_write && control.ar_load))
        else $error("Memory write and AR load in the same state");

endmodule

`default_nettype wire

// ==== verilog/alu.sv ====
`default_nettype none

module alu
    import basic_computer_pkg::*;
(
    input  alu_op_t operation,
    input  word_t   ac,
    input  word_t   dr,
    input  logic    e,
    output word_t   ac_next,
    output logic    e_next
);

    always_comb
    begin
        ac_next = ac;
        e_next = e;
        case (operation)
            alu_and:           ac_next = ac & dr;
            alu_add:           {e_next, ac_next} = {1'b0, ac} + {1'b0, dr};  // Carry into E
            alu_load:          ac_next = dr;
            alu_complement_ac: ac_next = ~ac;
            alu_complement_e:  e_next = ~e;
            alu_rotate_right:  {ac_next, e_next} = {e, ac};
            alu_rotate_left:   {e_next, ac_next} = {ac, e};
            alu_increment:     ac_next = ac + 16'd1;  // E left alone
            alu_clear_ac:      ac_next = '0;
            alu_clear_e:       e_next = 1'b0;
            default:
            begin
                ac_next = ac;
                e_next = e;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/register_file.sv ====
`default_nettype none

module register_file
    import basic_computer_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  control_word_t  control,
    input  word_t          memory_word,
    input  word_t          ac_next,
    input  logic           e_next,
    output addr_t          address,
    output word_t          bus,
    output word_t          ir,
    output word_t          dr,
    output machine_state_t status
);

    addr_t ar;
    addr_t pc;
    word_t ac;
    logic  e;

    ////////////////////////////////////////
    // Common bus
    ////////////////////////////////////////

    always_comb
    begin
        case (control.bus_source)
            bus_ar:     bus = {{(word_width - addr_width){1'b0}}, ar};
            bus_pc:     bus = {{(word_width - addr_width){1'b0}}, pc};
            bus_dr:     bus = dr;
            bus_ac:     bus = ac;
            bus_ir:     bus = ir;
            bus_memory: bus = memory_word;
            default:    bus = '0;
        endcase
    end

    ////////////////////////////////////////
    // Registers
    ////////////////////////////////////////

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            ar <= '0;
            pc <= '0;
            dr <= '0;
            ac <= '0;
            e <= 1'b0;
            ir <= '0;
        end
        else
        begin
            if (control.ar_load)
                ar <= bus[addr_width-1:0];
            else if (control.ar_increment)
                ar <= ar + 12'd1;

            if (control.pc_load)
                pc <= bus[addr_width-1:0];
            else if (control.pc_increment)
                pc <= pc + 12'd1;  // Fetch or skip

            if (control.dr_load)
                dr <= bus;
            else if (control.dr_increment)
                dr <= dr + 16'd1;

            if (control.ac_write)
            begin
                ac <= ac_next;
                e <= e_next;
            end

            if (control.ir_load)
                ir <= bus;
        end
    end

    assign address = ar;

    // Status tested by the skips and by ISZ
    assign status.pc = pc;
    assign status.ac = ac;
    assign status.e = e;
    assign status.ac_zero = (ac == '0);
    assign status.ac_sign = ac[word_width-1];
    assign status.dr_zero = (dr == '0);

endmodule

`default_nettype wire

// ==== verilog/main_memory.sv ====
`default_nettype none

module main_memory
    import basic_computer_pkg::*;
(
    input  logic          clock,
    input  control_word_t control,
    input  addr_t         address,
    input  word_t         bus,
    input  program_load_t program_load,
    input  logic          running,
    output word_t         memory_word,
    output store_event_t  store
);

    word_t ram [0:(1 << addr_width) - 1];

    assign memory_word = ram[address];  // Combinational read at AR

    always_ff @(posedge clock)
    begin
        if (control.memory_write)
            ram[address] <= bus;
        else if (program_load.valid && !running)
            ram[program_load.address] <= program_load.data;  // Loader only while stopped
    end

    // Store trace follows the write by one cycle
    always_ff @(posedge clock)
    begin
        store.valid <= control.memory_write;
        store.address <= address;
        store.data <= bus;
    end

    assert property (@(posedge clock)
        !(program_load.valid && !running && control.memory_write))
        else $error("Program load at %h collides with a memory write", program_load.address);

endmodule

`default_nettype wire

// ==== verilog/basic_computer.sv ====
`default_nettype none

module basic_computer
    import basic_computer_pkg::*;
(
    input  logic           clock,
    input  logic           reset,
    input  logic           start,
    input  program_load_t  program_load,
    output logic           running,
    output machine_state_t state,
    output store_event_t   store
);

    word_t          bus;
    word_t          ir;
    word_t          dr;
    word_t          memory_word;
    word_t          ac_next;
    logic           e_next;
    addr_t          address;
    decoded_instr_t decoded;
    control_word_t  control;
    machine_state_t status;

    instruction_decoder u_decoder (
        .ir      (ir),
        .decoded (decoded)
    );

    control_unit u_control (
        .clock   (clock),
        .reset   (reset),
        .start   (start),
        .decoded (decoded),
        .status  (status),
        .control (control),
        .running (running)
    );

    alu u_alu (
        .operation (control.alu_op),
        .ac        (status.ac),
        .dr        (dr),
        .e         (status.e),
        .ac_next   (ac_next),
        .e_next    (e_next)
    );

    register_file u_registers (
        .clock       (clock),
        .reset       (reset),
        .control     (control),
        .memory_word (memory_word),
        .ac_next     (ac_next),
        .e_next      (e_next),
        .address     (address),
        .bus         (bus),
        .ir          (ir),
        .dr          (dr),
        .status      (status)
    );

    main_memory u_memory (
        .clock        (clock),
        .control      (control),
        .address      (address),
        .bus          (bus),
        .program_load (program_load),
        .running      (running),
        .memory_word  (memory_word),
        .store        (store)
    );

    // PC, AC and E only
    assign state = {status.pc, status.ac, status.e, 3'b000};

endmodule

`default_nettype wire

// ==== test/basic_computer_tb.sv ====
`default_nettype none

module basic_computer_tb
    import basic_computer_pkg::*;
;

    logic           clock = 1'b0;
    logic           reset;
    logic           start;
    program_load_t  program_load;
    logic           running;
    machine_state_t state;
    store_event_t   store;

    // Program image and the model's copy of memory
    addr_t load_address [$];
    word_t load_data [$];
    word_t model_memory [0:(1 << addr_width) - 1];

    // Expected results from the model
    addr_t expected_address [0:31];
    word_t expected_data [0:31];
    int    expected_count;
    addr_t expected_pc;
    word_t expected_ac;
    logic  expected_e;

    int    store_index;
    addr_t next_address;
    word_t next_data;
    int    error_count = 0;
    int    test_count = 0;

    basic_computer uut (
        .clock        (clock),
        .reset        (reset),
        .start        (start),
        .program_load (program_load),
        .running      (running),
        .state        (state),
        .store        (store)
    );

    always #20 clock = ~clock;  // Period 40

    always @(posedge clock)
    begin
        if (reset)
            store_index <= 0;
        else if (store.valid)
            store_index <= store_index + 1;
    end

    assign next_address = expected_address[store_index];
    assign next_data = expected_data[store_index];

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    assert property (@(posedge clock) $fell(reset) |-> !running)
        else begin
            $display("ERROR running after reset: got %h expected 0", $sampled(running));
            error_count++;
        end

    assert property (@(posedge clock) $fell(reset) |-> !store.valid)
        else begin
            $display("ERROR store.valid after reset: got %h expected 0", $sampled(store.valid));
            error_count++;
        end

    assert property (@(posedge clock)
        $fell(reset) |-> (state.pc == '0 && state.ac == '0 && state.e == 1'b0))
        else begin
            $display("ERROR state after reset: pc %h ac %h e %h, expected all 0",
                $sampled(state.pc), $sampled(state.ac), $sampled(state.e));
            error_count++;
        end

    // Start while stopped raises running
    assert property (@(posedge clock) disable iff (reset) $past(start && !running) |-> running)
        else begin
            $display("ERROR running after start: got %h expected 1", $sampled(running));
            error_count++;
        end

    assert property (@(posedge clock) disable iff (reset)
        store.valid |-> store_index < expected_count)
        else begin
            $display("Unexpected store event to address %h beyond the %0d expected ones",
                $sampled(store.address), expected_count);
            error_count++;
        end

    assert property (@(posedge clock) disable iff (reset)
        (store.valid && store_index < expected_count) |-> store.address == next_address)
        else begin
            $display("ERROR store.address: got %h expected %h",
                $sampled(store.address), $sampled(next_address));
            error_count++;
        end

    assert property (@(posedge clock) disable iff (reset)
        (store.valid && store_index < expected_count) |-> store.data == next_data)
        else begin
            $display("ERROR store.data: got %h expected %h",
                $sampled(store.data), $sampled(next_data));
            error_count++;
        end

    // Final state once HLT has stopped the machine
    assert property (@(posedge clock) disable iff (reset)
        $fell(running) |-> store_index == expected_count)
        else begin
            $display("ERROR store count: got %h expected %h",
                $sampled(store_index), expected_count);
            error_count++;
        end

    assert property (@(posedge clock) disable iff (reset) $fell(running) |-> state.pc == expected_pc)
        else begin
            $display("ERROR state.pc: got %h expected %h", $sampled(state.pc), expected_pc);
            error_count++;
        end

    assert property (@(posedge clock) disable iff (reset) $fell(running) |-> state.ac == expected_ac)
        else begin
            $display("ERROR state.ac: got %h expected %h", $sampled(state.ac), expected_ac);
            error_count++;
        end

    assert property (@(posedge clock) disable iff (reset) $fell(running) |-> state.e == expected_e)
        else begin
            $display("ERROR state.e: got %h expected %h", $sampled(state.e), expected_e);
            error_count++;
        end

    ////////////////////////////////////////
    // Program building and model
    ////////////////////////////////////////

    function automatic word_t memory_instruction(opcode_t op, logic indirect, addr_t target);
        return {indirect, op, target};
    endfunction

    function automatic word_t register_instruction(int position);
        word_t instruction;
        instruction = {1'b0, op_register, 12'h000};
        instruction[position] = 1'b1;
        return instruction;
    endfunction

    function automatic word_t random_word();
        logic [31:0] value;
        value = $urandom;
        return value[15:0];
    endfunction

    task automatic clear_program();
        int i;
        load_address.delete();
        load_data.delete();
        for (i = 0; i < (1 << addr_width); i++)
            model_memory[i] = '0;
    endtask

    task automatic put_word(addr_t address, word_t data);
        load_address.push_back(address);
        load_data.push_back(data);
        model_memory[address] = data;
    endtask

    task automatic record_store(addr_t address, word_t data);
        model_memory[address] = data;
        expected_address[expected_count] = address;
        expected_data[expected_count] = data;
        expected_count++;
    endtask

    // Instruction-level model of the machine that runs from PC 0 until HLT
    task automatic run_model();
        addr_t pc;
        addr_t target;
        word_t ac;
        word_t ir;
        word_t value;
        logic  e;
        logic  carry;
        logic  halted;
        int    steps;
        pc = '0;
        ac = '0;
        e = 1'b0;
        halted = 1'b0;
        expected_count = 0;
        for (steps = 0; steps < 200 && !halted; steps++)
        begin
            ir = model_memory[pc];
            pc = pc + 12'd1;
            if (ir[14:12] != op_register)
            begin
                target = ir[11:0];
                if (ir[15])
                    target = model_memory[target][11:0];  // Pointer word
                case (ir[14:12])
                    op_and: ac = ac & model_memory[target];
                    op_add: {e, ac} = {1'b0, ac} + {1'b0, model_memory[target]};
                    op_lda: ac = model_memory[target];
                    op_sta: record_store(target, ac);
                    op_bun: pc = target;
                    op_bsa:
                    begin
                        record_store(target, {4'h0, pc});  // Return address
                        pc = target + 12'd1;
                    end
                    default:
                    begin
                        value = model_memory[target] + 16'd1;
                        record_store(target, value);
                        if (value == '0)
                            pc = pc + 12'd1;
                    end
                endcase
            end
            else if (!ir[15] && $onehot(ir[11:0]))
            begin
                if (ir[rr_cla]) ac = '0;
                if (ir[rr_cle]) e = 1'b0;
                if (ir[rr_cma]) ac = ~ac;
                if (ir[rr_cme]) e = ~e;
                if (ir[rr_cir])
                begin
                    carry = ac[0];
                    ac = {e, ac[15:1]};
                    e = carry;
                end
                if (ir[rr_cil])
                begin
                    carry = ac[15];
                    ac = {ac[14:0], e};
                    e = carry;
                end
                if (ir[rr_inc]) ac = ac + 16'd1;
                if ((ir[rr_spa] && !ac[15]) || (ir[rr_sna] && ac[15]) ||
                    (ir[rr_sza] && ac == '0) || (ir[rr_sze] && !e))
                    pc = pc + 12'd1;
                if (ir[rr_hlt]) halted = 1'b1;
            end
        end
        if (!halted)
        begin
            $display("Model did not reach HLT within 200 instructions");
            error_count++;
        end
        expected_pc = pc;
        expected_ac = ac;
        expected_e = e;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    task automatic apply_reset();
        int cycle;
        @(posedge clock);
        reset <= 1'b1;
        start <= 1'b0;
        program_load <= '0;
        for (cycle = 0; cycle < 16; cycle++)
            @(posedge clock);
        reset <= 1'b0;
    endtask

    task automatic load_program();
        int i;
        for (i = 0; i < load_address.size(); i++)
        begin
            @(posedge clock);
            program_load.valid <= 1'b1;
            program_load.address <= load_address[i];
            program_load.data <= load_data[i];
        end
        @(posedge clock);
        program_load <= '0;
    endtask

    task automatic wait_for_running(logic level, int limit);
        int cycle;
        for (cycle = 0; cycle < limit; cycle++)
        begin
            @(negedge clock);
            if (running == level)
                return;
        end
        $display("Timeout: running did not become %0d within %0d cycles", level, limit);
        error_count++;
    endtask

    task automatic run_test(int number, string name);
        int errors_before;
        errors_before = error_count;
        apply_reset();
        load_program();
        run_model();
        @(posedge clock);
        start <= 1'b1;
        @(posedge clock);
        start <= 1'b0;
        wait_for_running(1'b1, 8);
        wait_for_running(1'b0, 500);
        repeat (2) @(posedge clock);  // Let the halt checks fire
        test_count++;
        $display("test %0d %s: %0d errors", number, name, error_count - errors_before);
    endtask

    initial
    begin
        word_t operand_a;
        word_t operand_b;
        reset = 1'b1;
        start = 1'b0;
        program_load = '0;
        void'($urandom(16280));

        clear_program();
        put_word(12'd0, register_instruction(rr_hlt));
        run_test(1, "reset and start");

        clear_program();
        operand_a = random_word() | 16'h8000;  // Both high so ADD carries
        operand_b = random_word() | 16'h8000;
        put_word(12'd0, memory_instruction(op_lda, 1'b0, 12'd10));
        put_word(12'd1, memory_instruction(op_add, 1'b0, 12'd11));
        put_word(12'd2, memory_instruction(op_sta, 1'b0, 12'd12));
        put_word(12'd3, memory_instruction(op_and, 1'b0, 12'd13));
        put_word(12'd4, memory_instruction(op_sta, 1'b0, 12'd14));
        put_word(12'd5, register_instruction(rr_hlt));
        put_word(12'd10, operand_a);
        put_word(12'd11, operand_b);
        put_word(12'd13, random_word());
        run_test(2, "arithmetic");

        clear_program();
        put_word(12'd0, memory_instruction(op_lda, 1'b1, 12'd20));
        put_word(12'd1, memory_instruction(op_sta, 1'b1, 12'd21));
        put_word(12'd2, memory_instruction(op_bun, 1'b0, 12'd4));
        put_word(12'd3, memory_instruction(op_sta, 1'b0, 12'd50));  // Trap
        put_word(12'd4, memory_instruction(op_sta, 1'b0, 12'd41));
        put_word(12'd5, register_instruction(rr_hlt));
        put_word(12'd20, 16'd30);
        put_word(12'd21, 16'd40);
        put_word(12'd30, random_word());
        run_test(3, "indirect and BUN");

        clear_program();
        put_word(12'd0, memory_instruction(op_lda, 1'b0, 12'd30));
        put_word(12'd1, register_instruction(rr_cle));
        put_word(12'd2, register_instruction(rr_cma));
        put_word(12'd3, memory_instruction(op_sta, 1'b0, 12'd31));
        put_word(12'd4, register_instruction(rr_cme));
        put_word(12'd5, register_instruction(rr_cir));
        put_word(12'd6, memory_instruction(op_sta, 1'b0, 12'd32));
        put_word(12'd7, register_instruction(rr_cil));
        put_word(12'd8, memory_instruction(op_sta, 1'b0, 12'd33));
        put_word(12'd9, register_instruction(rr_inc));
        put_word(12'd10, memory_instruction(op_sta, 1'b0, 12'd34));
        put_word(12'd11, register_instruction(rr_cla));
        put_word(12'd12, memory_instruction(op_sta, 1'b0, 12'd35));
        put_word(12'd13, register_instruction(rr_hlt));
        put_word(12'd30, random_word());
        run_test(4, "register operations");

        clear_program();
        put_word(12'd0, memory_instruction(op_lda, 1'b0, 12'd60));
        put_word(12'd1, register_instruction(rr_spa));
        put_word(12'd2, memory_instruction(op_sta, 1'b0, 12'd70));
        put_word(12'd3, memory_instruction(op_sta, 1'b0, 12'd71));
        put_word(12'd4, register_instruction(rr_sna));
        put_word(12'd5, memory_instruction(op_sta, 1'b0, 12'd72));
        put_word(12'd6, memory_instruction(op_sta, 1'b0, 12'd73));
        put_word(12'd7, register_instruction(rr_cma));  // AC now negative
        put_word(12'd8, register_instruction(rr_sna));
        put_word(12'd9, memory_instruction(op_sta, 1'b0, 12'd74));
        put_word(12'd10, memory_instruction(op_sta, 1'b0, 12'd75));
        put_word(12'd11, register_instruction(rr_cla));
        put_word(12'd12, register_instruction(rr_sza));
        put_word(12'd13, memory_instruction(op_sta, 1'b0, 12'd76));
        put_word(12'd14, memory_instruction(op_sta, 1'b0, 12'd77));
        put_word(12'd15, register_instruction(rr_cle));
        put_word(12'd16, register_instruction(rr_sze));
        put_word(12'd17, memory_instruction(op_sta, 1'b0, 12'd78));
        put_word(12'd18, memory_instruction(op_sta, 1'b0, 12'd79));
        put_word(12'd19, memory_instruction(op_isz, 1'b0, 12'd61));
        put_word(12'd20, memory_instruction(op_sta, 1'b0, 12'd80));
        put_word(12'd21, memory_instruction(op_isz, 1'b0, 12'd62));
        put_word(12'd22, memory_instruction(op_sta, 1'b0, 12'd81));
        put_word(12'd23, register_instruction(rr_hlt));
        put_word(12'd60, (random_word() & 16'h7fff) | 16'h0001);  // Positive and nonzero
        put_word(12'd61, 16'hffff);
        put_word(12'd62, 16'd5);
        run_test(5, "skips and ISZ");

        clear_program();
        put_word(12'd0, memory_instruction(op_lda, 1'b0, 12'd90));
        put_word(12'd1, memory_instruction(op_bsa, 1'b0, 12'd100));
        put_word(12'd2, memory_instruction(op_sta, 1'b0, 12'd91));
        put_word(12'd3, register_instruction(rr_hlt));
        put_word(12'd90, random_word());
        put_word(12'd100, 16'h0000);  // Return word
        put_word(12'd101, memory_instruction(op_sta, 1'b0, 12'd92));
        put_word(12'd102, memory_instruction(op_bun, 1'b1, 12'd100));
        run_test(6, "BSA and return");

        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== basic_computer.f ====
verilog/basic_computer_pkg.sv
verilog/instruction_decoder.sv
verilog/control_unit.sv
verilog/alu.sv
verilog/register_file.sv
verilog/main_memory.sv
verilog/basic_computer.sv
test/basic_computer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --top-module basic_computer_tb \
    -f basic_computer.f -Mdir obj_dir -o basic_computer_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/basic_computer_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
